// ==== rvPkg.sv ====
`default_nettype none

package rvPkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    typedef enum logic [1:0] {
        ALUOP_ADD    = 2'b00,
        ALUOP_BRANCH = 2'b01,
        ALUOP_FUNCT  = 2'b10,
        ALUOP_PASSB  = 2'b11
    } aluOp_t;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'b0000,
        ALU_SUB   = 4'b0001,
        ALU_AND   = 4'b0010,
        ALU_OR    = 4'b0011,
        ALU_XOR   = 4'b0100,
        ALU_SLL   = 4'b0101,
        ALU_SRL   = 4'b0110,
        ALU_SRA   = 4'b0111,
        ALU_SLT   = 4'b1000,
        ALU_SLTU  = 4'b1001,
        ALU_PASSB = 4'b1010
    } aluCtrl_t;

    typedef enum logic [2:0] {
        IMM_I    = 3'b000,
        IMM_S    = 3'b001,
        IMM_B    = 3'b010,
        IMM_U    = 3'b011,
        IMM_J    = 3'b100,
        IMM_NONE = 3'b111 // Immediate is zero
    } immSrc_t;

    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10
    } resultSrc_t;

    typedef enum logic [2:0] {
        MEM_NONE  = 3'b000,
        MEM_WORD  = 3'b001,
        MEM_HALF  = 3'b010,
        MEM_BYTE  = 3'b011,
        MEM_HALFU = 3'b100,
        MEM_BYTEU = 3'b101
    } memMode_t;

    typedef struct packed {
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] pcPlus4;
    } fetchBundle_t;

    typedef struct packed {
        logic       regWrite;
        resultSrc_t resultSrc;
        logic       memWrite;
        logic       memRead;
        logic       jump;
        logic       branch;
        aluCtrl_t   aluControl;
        logic       aluSrc;
        logic       srcAPc;     // Operand A is the PC
        memMode_t   memMode;
        logic       illegal;
    } ctrlBundle_t;

    typedef struct packed {
        ctrlBundle_t           ctrl;
        logic [XLEN-1:0]       rd1;
        logic [XLEN-1:0]       rd2;
        logic [XLEN-1:0]       immExt;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       pcPlus4;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [2:0]            funct3; // Branch condition for execute
    } decodeBundle_t;

endpackage

`default_nettype wire

// ==== aluDecoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module aluDecoder
    import rvPkg::*;
(
    input  aluOp_t     aluOp,
    input  logic       opBit5,
    input  logic [2:0] funct3,
    input  logic       funct7Bit5,
    output aluCtrl_t   aluControl
);

    always_comb begin
        case (aluOp)
            ALUOP_ADD:   aluControl = ALU_ADD;
            ALUOP_PASSB: aluControl = ALU_PASSB; // lui
            ALUOP_BRANCH: begin
                case (funct3)
                    3'b100,
                    3'b101:  aluControl = ALU_SLT;  // blt, bge
                    3'b110,
                    3'b111:  aluControl = ALU_SLTU; // bltu, bgeu
                    default: aluControl = ALU_SUB;  // beq, bne
                endcase
            end
            default: begin
                case (funct3)
                    3'b000: begin
                        // Only R-type has a sub form
                        if (opBit5 && funct7Bit5) aluControl = ALU_SUB;
                        else aluControl = ALU_ADD;
                    end
                    3'b001: aluControl = ALU_SLL;
                    3'b010: aluControl = ALU_SLT;
                    3'b011: aluControl = ALU_SLTU;
                    3'b100: aluControl = ALU_XOR;
                    3'b101: begin
                        if (funct7Bit5) aluControl = ALU_SRA;
                        else aluControl = ALU_SRL;
                    end
                    3'b110: aluControl = ALU_OR;
                    default: aluControl = ALU_AND;
                endcase
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== controlUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module controlUnit
    import rvPkg::*;
(
    input  logic [XLEN-1:0] instr,
    output ctrlBundle_t     ctrl,
    output immSrc_t         immSrc
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    aluOp_t      aluOp;
    aluCtrl_t    aluCtrl;
    ctrlBundle_t mainCtrl;
    logic        isLoad;
    logic        isStore;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    always_comb begin
        mainCtrl = '0;
        immSrc   = IMM_NONE;
        aluOp    = ALUOP_ADD;
        isLoad   = 1'b0;
        isStore  = 1'b0;
        case (opcode)
            OP_R: begin
                mainCtrl.regWrite = 1'b1;
                aluOp             = ALUOP_FUNCT;
            end
            OP_I: begin
                mainCtrl.regWrite = 1'b1;
                mainCtrl.aluSrc   = 1'b1;
                immSrc            = IMM_I;
                aluOp             = ALUOP_FUNCT;
            end
            OP_LOAD: begin
                mainCtrl.regWrite  = 1'b1;
                mainCtrl.aluSrc    = 1'b1;
                mainCtrl.memRead   = 1'b1;
                mainCtrl.resultSrc = RES_MEM;
                immSrc             = IMM_I;
                isLoad             = 1'b1;
            end
            OP_STORE: begin
                mainCtrl.aluSrc   = 1'b1;
                mainCtrl.memWrite = 1'b1;
                immSrc            = IMM_S;
                isStore           = 1'b1;
            end
            OP_BRANCH: begin
                mainCtrl.branch = 1'b1;
                immSrc          = IMM_B;
                aluOp           = ALUOP_BRANCH; // Compare rs1 with rs2
            end
            OP_LUI: begin
                mainCtrl.regWrite = 1'b1;
                mainCtrl.aluSrc   = 1'b1;
                immSrc            = IMM_U;
                aluOp             = ALUOP_PASSB;
            end
            OP_AUIPC: begin
                mainCtrl.regWrite = 1'b1;
                mainCtrl.aluSrc   = 1'b1;
                mainCtrl.srcAPc   = 1'b1; // PC plus upper immediate
                immSrc            = IMM_U;
            end
            OP_JAL: begin
                mainCtrl.regWrite  = 1'b1;
                mainCtrl.jump      = 1'b1;
                mainCtrl.resultSrc = RES_PC4;
                immSrc             = IMM_J;
            end
            OP_JALR: begin
                mainCtrl.regWrite  = 1'b1;
                mainCtrl.jump      = 1'b1;
                mainCtrl.aluSrc    = 1'b1; // Target is rs1 plus imm
                mainCtrl.resultSrc = RES_PC4;
                immSrc             = IMM_I;
            end
            default: mainCtrl.illegal = 1'b1;
        endcase

        if (isLoad || isStore) begin
            case (funct3)
                3'b000:  mainCtrl.memMode = MEM_BYTE;
                3'b001:  mainCtrl.memMode = MEM_HALF;
                3'b010:  mainCtrl.memMode = MEM_WORD;
                3'b100:  mainCtrl.memMode = isLoad ? MEM_BYTEU : MEM_NONE;
                3'b101:  mainCtrl.memMode = isLoad ? MEM_HALFU : MEM_NONE;
                default: mainCtrl.memMode = MEM_NONE;
            endcase
        end
    end

    always_comb begin
        ctrl            = mainCtrl;
        ctrl.aluControl = aluCtrl;
    end

    aluDecoder aluDecoder_inst (
        .aluOp      (aluOp),
        .opBit5     (opcode[5]),
        .funct3     (funct3),
        .funct7Bit5 (instr[30]),
        .aluControl (aluCtrl)
    );

endmodule

`default_nettype wire

// ==== immExtend.sv ====
`timescale 1ns/10ps
`default_nettype none

module immExtend
    import rvPkg::*;
(
    input  logic [XLEN-1:0] instr,
    input  immSrc_t         immSrc,
    output logic [XLEN-1:0] immExt
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (immSrc)
            IMM_I: immExt = {{20{sign}}, instr[31:20]};
            IMM_S: immExt = {{20{sign}}, instr[31:25], instr[11:7]};
            IMM_B: begin
                immExt = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            IMM_U: immExt = {instr[31:12], 12'b0};
            IMM_J: begin
                // Offset bits are scrambled across the word
                immExt = {{12{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: immExt = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== registerFile.sv ====
`timescale 1ns/10ps
`default_nettype none

module registerFile
    import rvPkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [REG_ADDR_W-1:0] rs1,
    input  logic [REG_ADDR_W-1:0] rs2,
    output logic [XLEN-1:0]       rd1,
    output logic [XLEN-1:0]       rd2,
    input  logic                  writeEnable,
    input  logic [REG_ADDR_W-1:0] writeAddr,
    input  logic [XLEN-1:0]       writeData
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];
    logic            writeValid;

    assign writeValid = writeEnable && (writeAddr != '0); // x0 stays zero

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (writeValid) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Write-first bypass
    assign rd1 = (rs1 == '0) ? '0 :
                 (writeValid && writeAddr == rs1) ? writeData : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 :
                 (writeValid && writeAddr == rs2) ? writeData : regs[rs2];

endmodule

`default_nettype wire

// ==== pipeReg.sv ====
`timescale 1ns/10ps
`default_nettype none

module pipeReg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     hold,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (reset || bubble) begin
            q <= '0; // Flush wins over hold
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// ==== decodeStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module decodeStage
    import rvPkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  fetchBundle_t          fetch,
    input  logic                  stallD,
    input  logic                  flushD,
    input  logic                  flushE,
    input  logic                  wbRegWrite,
    input  logic [REG_ADDR_W-1:0] wbRd,
    input  logic [XLEN-1:0]       wbResult,
    output decodeBundle_t         execute,
    output logic [REG_ADDR_W-1:0] rs1D,
    output logic [REG_ADDR_W-1:0] rs2D
);

    fetchBundle_t    fetchD;
    ctrlBundle_t     ctrlD;
    immSrc_t         immSrcD;
    logic [XLEN-1:0] immExtD;
    logic [XLEN-1:0] rd1D;
    logic [XLEN-1:0] rd2D;
    decodeBundle_t   decodeD;

    pipeReg #(
        .payload_t (fetchBundle_t)
    ) ifIdReg (
        .clk    (clk),
        .reset  (reset),
        .hold   (stallD),
        .bubble (flushD),
        .d      (fetch),
        .q      (fetchD)
    );

    assign rs1D = fetchD.instr[19:15];
    assign rs2D = fetchD.instr[24:20];

    controlUnit controlUnit_inst (
        .instr  (fetchD.instr),
        .ctrl   (ctrlD),
        .immSrc (immSrcD)
    );

    immExtend immExtend_inst (
        .instr  (fetchD.instr),
        .immSrc (immSrcD),
        .immExt (immExtD)
    );

    registerFile registerFile_inst (
        .clk         (clk),
        .reset       (reset),
        .rs1         (rs1D),
        .rs2         (rs2D),
        .rd1         (rd1D),
        .rd2         (rd2D),
        .writeEnable (wbRegWrite),
        .writeAddr   (wbRd),
        .writeData   (wbResult)
    );

    assign decodeD = '{
        ctrl:    ctrlD,
        rd1:     rd1D,
        rd2:     rd2D,
        immExt:  immExtD,
        pc:      fetchD.pc,
        pcPlus4: fetchD.pcPlus4,
        rs1:     rs1D,
        rs2:     rs2D,
        rd:      fetchD.instr[11:7],
        funct3:  fetchD.instr[14:12]
    };

    pipeReg #(
        .payload_t (decodeBundle_t)
    ) idExReg (
        .clk    (clk),
        .reset  (reset),
        .hold   (1'b0), // Execute never stalls here
        .bubble (flushE),
        .d      (decodeD),
        .q      (execute)
    );

endmodule

`default_nettype wire

// ==== decodeStage_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module decodeStage_tb
    import rvPkg::*;
;

    localparam int CYCLE_LIMIT = 3000;

    logic                  clk;
    logic                  reset;
    fetchBundle_t          fetch;
    logic                  stallD;
    logic                  flushD;
    logic                  flushE;
    logic                  wbRegWrite;
    logic [REG_ADDR_W-1:0] wbRd;
    logic [XLEN-1:0]       wbResult;
    decodeBundle_t         execute;
    logic [REG_ADDR_W-1:0] rs1D;
    logic [REG_ADDR_W-1:0] rs2D;

    logic [XLEN-1:0] shadow [32];   // Expected register contents
    logic [31:0]     lfsr = 32'h5e30;
    int              cycleCount = 0;

    decodeStage decodeStage_inst (
        .clk        (clk),
        .reset      (reset),
        .fetch      (fetch),
        .stallD     (stallD),
        .flushD     (flushD),
        .flushE     (flushE),
        .wbRegWrite (wbRegWrite),
        .wbRd       (wbRd),
        .wbResult   (wbResult),
        .execute    (execute),
        .rs1D       (rs1D),
        .rs2D       (rs2D)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $fatal(1, "Simulation timed out");
        end
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] randBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return value;
    endfunction

    function automatic aluCtrl_t expectedAlu(input logic [2:0] f3, input logic f7b5,
                                             input logic isR);
        case (f3)
            3'd0: return (isR && f7b5) ? ALU_SUB : ALU_ADD;
            3'd1: return ALU_SLL;
            3'd2: return ALU_SLT;
            3'd3: return ALU_SLTU;
            3'd4: return ALU_XOR;
            3'd5: return f7b5 ? ALU_SRA : ALU_SRL;
            3'd6: return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic memMode_t loadWidth(input logic [2:0] f3);
        case (f3)
            3'd0: return MEM_BYTE;
            3'd1: return MEM_HALF;
            3'd2: return MEM_WORD;
            3'd4: return MEM_BYTEU;
            3'd5: return MEM_HALFU;
            default: return MEM_NONE;
        endcase
    endfunction

    function automatic decodeBundle_t decodeModel(input logic [31:0] instr,
                                                  input logic [31:0] pc,
                                                  input logic [31:0] pcPlus4);
        decodeBundle_t d;
        logic [31:0]   immI;
        logic [31:0]   immS;
        logic [31:0]   immB;
        logic [31:0]   immJ;
        logic [2:0]    f3;
        d = '0;
        f3 = instr[14:12];
        immI = $signed(instr) >>> 20;
        immS = {immI[31:5], instr[11:7]};
        immB = '0;
        immB[12] = instr[31];
        immB[11] = instr[7];
        immB[10:5] = instr[30:25];
        immB[4:1] = instr[11:8];
        immB = $signed(immB << 19) >>> 19;   // Sign from offset bit 12
        immJ = '0;
        immJ[20] = instr[31];
        immJ[19:12] = instr[19:12];
        immJ[11] = instr[20];
        immJ[10:1] = instr[30:21];
        immJ = $signed(immJ << 11) >>> 11;   // Sign from offset bit 20
        d.ctrl.aluControl = ALU_ADD;
        case (instr[6:0])
            OP_R: begin
                d.ctrl.regWrite = 1'b1;
                d.ctrl.aluControl = expectedAlu(f3, instr[30], 1'b1);
            end
            OP_I: begin
                {d.ctrl.regWrite, d.ctrl.aluSrc} = 2'b11;
                d.ctrl.aluControl = expectedAlu(f3, instr[30], 1'b0);
                d.immExt = immI;
            end
            OP_LOAD: begin
                {d.ctrl.regWrite, d.ctrl.aluSrc, d.ctrl.memRead} = 3'b111;
                d.ctrl.resultSrc = RES_MEM;
                d.ctrl.memMode = loadWidth(f3);
                d.immExt = immI;
            end
            OP_STORE: begin
                {d.ctrl.aluSrc, d.ctrl.memWrite} = 2'b11;
                d.ctrl.memMode = (f3 > 3'd2) ? MEM_NONE : loadWidth(f3);
                d.immExt = immS;
            end
            OP_BRANCH: begin
                d.ctrl.branch = 1'b1;
                d.ctrl.aluControl = !f3[2] ? ALU_SUB : (f3[1] ? ALU_SLTU : ALU_SLT);
                d.immExt = immB;
            end
            OP_LUI: begin
                {d.ctrl.regWrite, d.ctrl.aluSrc} = 2'b11;
                d.ctrl.aluControl = ALU_PASSB;
                d.immExt = instr & 32'hffff_f000;
            end
            OP_AUIPC: begin
                {d.ctrl.regWrite, d.ctrl.aluSrc, d.ctrl.srcAPc} = 3'b111;
                d.immExt = instr & 32'hffff_f000;
            end
            OP_JAL: begin
                {d.ctrl.regWrite, d.ctrl.jump} = 2'b11;
                d.ctrl.resultSrc = RES_PC4;
                d.immExt = immJ;
            end
            OP_JALR: begin
                {d.ctrl.regWrite, d.ctrl.jump, d.ctrl.aluSrc} = 3'b111;
                d.ctrl.resultSrc = RES_PC4;
                d.immExt = immI;
            end
            default: d.ctrl.illegal = 1'b1;
        endcase
        d.rs1 = instr[19:15];
        d.rs2 = instr[24:20];
        d.rd1 = (d.rs1 == 5'd0) ? 32'd0 : shadow[d.rs1];
        d.rd2 = (d.rs2 == 5'd0) ? 32'd0 : shadow[d.rs2];
        d.rd = instr[11:7];
        d.funct3 = f3;
        d.pc = pc;
        d.pcPlus4 = pcPlus4;
        return d;
    endfunction

    task automatic checkValue(input string name, input logic [255:0] actual,
                              input logic [255:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s = 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic compareExecute(input decodeBundle_t want);
        checkValue("execute.ctrl", 256'(execute.ctrl), 256'(want.ctrl));
        checkValue("execute.rd1", 256'(execute.rd1), 256'(want.rd1));
        checkValue("execute.rd2", 256'(execute.rd2), 256'(want.rd2));
        checkValue("execute.immExt", 256'(execute.immExt), 256'(want.immExt));
        checkValue("execute.pc", 256'(execute.pc), 256'(want.pc));
        checkValue("execute.pcPlus4", 256'(execute.pcPlus4), 256'(want.pcPlus4));
        checkValue("execute.rs1", 256'(execute.rs1), 256'(want.rs1));
        checkValue("execute.rs2", 256'(execute.rs2), 256'(want.rs2));
        checkValue("execute.rd", 256'(execute.rd), 256'(want.rd));
        checkValue("execute.funct3", 256'(execute.funct3), 256'(want.funct3));
    endtask

    // Starts 1 ns after an edge. Writeback lands in the decode cycle
    task automatic runInstr(input logic [31:0] instr, input logic wrEn,
                            input logic [4:0] wrAddr, input logic [31:0] wrData);
        decodeBundle_t want;
        logic [31:0]   pc;
        pc = {30'(randBits(30)), 2'b00};
        fetch = '{instr: instr, pc: pc, pcPlus4: pc + 32'd4};
        @(posedge clk);
        #1;
        {wbRegWrite, wbRd, wbResult} = {wrEn, wrAddr, wrData};
        if (wrEn && wrAddr != 5'd0) shadow[wrAddr] = wrData;
        want = decodeModel(instr, pc, pc + 32'd4);
        @(posedge clk);
        #1;
        wbRegWrite = 1'b0;
        compareExecute(want);
    endtask

    task automatic writeReg(input logic [4:0] addr, input logic [31:0] data);
        {wbRegWrite, wbRd, wbResult} = {1'b1, addr, data};
        if (addr != 5'd0) shadow[addr] = data;
        @(posedge clk);
        #1;
        wbRegWrite = 1'b0;
    endtask

    task automatic resetBubble();
        repeat (16) begin
            @(posedge clk);
            #1;
            checkValue("execute", 256'(execute), '0);
        end
        reset = 1'b0;
        repeat (2) begin
            @(posedge clk);
            #1;
            checkValue("execute flags", 256'({execute.ctrl.regWrite, execute.ctrl.memWrite,
                       execute.ctrl.memRead, execute.ctrl.jump, execute.ctrl.branch}), '0);
        end
    endtask

    task automatic controlDecode();
        logic [6:0] opList [13];
        opList = '{OP_R, OP_I, OP_LOAD, OP_STORE, OP_BRANCH, OP_LUI, OP_AUIPC, OP_JAL,
                   OP_JALR, 7'b0000000, 7'b0001111, 7'b1110011, 7'b1111111};
        for (int op = 0; op < 13; op++) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                runInstr({17'(randBits(17)), f3[2:0], 5'(randBits(5)), opList[op]},
                         1'b0, 5'd0, 32'd0);
            end
        end
    endtask

    task automatic aluControlDecode();
        logic [31:0] instr;
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int f7 = 0; f7 < 2; f7++) begin
                instr = {1'b0, f7[0], 5'b0, 10'(randBits(10)), f3[2:0], 5'(randBits(5)), OP_R};
                runInstr(instr, 1'b0, 5'd0, 32'd0);
                instr[6:0] = OP_I;
                runInstr(instr, 1'b0, 5'd0, 32'd0);
            end
            instr = {17'(randBits(17)), f3[2:0], 5'(randBits(5)), OP_BRANCH};
            runInstr(instr, 1'b0, 5'd0, 32'd0);
            runInstr({instr[31:7], OP_LOAD}, 1'b0, 5'd0, 32'd0);
            runInstr({instr[31:7], OP_STORE}, 1'b0, 5'd0, 32'd0);
            runInstr({instr[31:7], OP_LUI}, 1'b0, 5'd0, 32'd0);
        end
    endtask

    task automatic immediateFormats();
        logic [6:0] fmt [6];
        fmt = '{OP_I, OP_STORE, OP_BRANCH, OP_LUI, OP_JAL, OP_AUIPC};
        for (int k = 0; k < 6; k++) begin
            repeat (16) runInstr({25'(randBits(25)), fmt[k]}, 1'b0, 5'd0, 32'd0);
        end
    endtask

    task automatic registerAccess();
        logic [4:0] addr;
        for (int i = 0; i < 24; i++) begin
            addr = 5'(randBits(5));
            writeReg(addr, randBits(32));
            runInstr({7'b0, 5'(randBits(5)), addr, 3'b0, 5'(randBits(5)), OP_R},
                     1'b0, 5'd0, 32'd0);
        end
        repeat (16) runInstr({7'b0, 10'(randBits(10)), 3'b0, 5'd1, OP_R}, 1'b0, 5'd0, 32'd0);
        writeReg(5'd0, 32'hffff_ffff);   // x0 ignores writes
        runInstr({7'b0, 5'd0, 5'd0, 3'b0, 5'd2, OP_R}, 1'b1, 5'd0, 32'h1234_5678);
        repeat (12) begin
            addr = 5'(randBits(5));
            runInstr({7'b0, addr, addr, 3'b0, 5'(randBits(5)), OP_R}, 1'b1, addr, randBits(32));
        end
    endtask

    task automatic stallAndFlush();
        logic [31:0]   instrA;
        logic [31:0]   instrB;
        decodeBundle_t bubbleD;
        instrA = {25'(randBits(25)), OP_R};
        instrB = {25'(randBits(25)), OP_I};
        bubbleD = decodeModel(32'd0, 32'd0, 32'd0);
        fetch = '{instr: instrA, pc: 32'h100, pcPlus4: 32'h104};
        @(posedge clk);
        #1;
        fetch = '{instr: instrB, pc: 32'h104, pcPlus4: 32'h108};
        stallD = 1'b1;
        repeat (3) begin
            @(posedge clk);
            #1;
            checkValue("rs1D", 256'(rs1D), 256'(instrA[19:15]));
            checkValue("rs2D", 256'(rs2D), 256'(instrA[24:20]));
        end
        stallD = 1'b0;
        @(posedge clk);
        #1;
        checkValue("rs1D", 256'(rs1D), 256'(instrB[19:15]));
        flushD = 1'b1;
        @(posedge clk);
        #1;
        flushD = 1'b0;
        compareExecute(decodeModel(instrB, 32'h104, 32'h108));
        @(posedge clk);
        #1;
        compareExecute(bubbleD);   // Zero instruction reached execute
        flushE = 1'b1;
        @(posedge clk);
        #1;
        flushE = 1'b0;
        checkValue("execute", 256'(execute), '0);
        {flushD, stallD} = 2'b11;   // Flush beats stall
        @(posedge clk);
        #1;
        {flushD, stallD} = 2'b00;
        checkValue("rs1D", 256'(rs1D), '0);
        checkValue("rs2D", 256'(rs2D), '0);
        @(posedge clk);
        #1;
        compareExecute(bubbleD);
    endtask

    initial begin
        reset = 1'b1;
        fetch = '0;
        {stallD, flushD, flushE} = 3'b000;
        {wbRegWrite, wbRd, wbResult} = '0;
        for (int i = 0; i < 32; i++) shadow[i] = '0;
        resetBubble();
        controlDecode();
        aluControlDecode();
        immediateFormats();
        registerAccess();
        stallAndFlush();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
rvPkg.sv
aluDecoder.sv
controlUnit.sv
immExtend.sv
registerFile.sv
pipeReg.sv
decodeStage.sv
decodeStage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TB_TOP    ?= decodeStage_tb
RTL_TOP   ?= decodeStage
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
